// ==== fw_accel.f ====
src/fw_accel_pkg.sv
src/fw_rule_pkg.sv
src/mmio_decode.sv
src/fw_rule_table.sv
src/fw_matcher.sv
src/mmio_result.sv
src/fw_accel_top.sv
testbench/fw_accel_tb.sv

// ==== testbench/fw_accel_tb.sv ====
`timescale 1ns/100ps

module fw_accel_tb;

  import fw_accel_pkg::*;
  import fw_rule_pkg::*;

  localparam int READ_TIMEOUT = 40;

  logic                     clk;
  logic                     rst;
  logic                     io_en;
  logic                     io_wen;
  logic [IO_STRB_WIDTH-1:0] io_strb;
  logic [IO_ADDR_WIDTH-1:0] io_addr;
  logic [IO_DATA_WIDTH-1:0] io_wr_data;
  logic [IO_DATA_WIDTH-1:0] io_rd_data;
  logic                     io_rd_valid;
  logic                     rule_wr_en;
  logic [SLOT_W-1:0]        rule_wr_slot;
  logic [IP_W-1:0]          rule_wr_prefix;
  logic [PREFIX_LEN_W-1:0]  rule_wr_len;
  logic                     rule_wr_valid;

  // Reference copy of the rule table and of the source register
  logic [IP_W-1:0]          ref_prefix [SLOT_COUNT];
  int                       ref_len    [SLOT_COUNT];
  bit                       ref_valid  [SLOT_COUNT];
  logic [IO_DATA_WIDTH-1:0] model_src;

  logic [15:0]              lfsr_state;
  int                       mismatch_count;
  int                       timeout_count;

  fw_accel_top UUT (
    .clk, .rst,
    .io_en, .io_wen, .io_strb, .io_addr, .io_wr_data, .io_rd_data, .io_rd_valid,
    .rule_wr_en, .rule_wr_slot, .rule_wr_prefix, .rule_wr_len, .rule_wr_valid
  );

  always #10 clk = ~clk;

  // Taps 16, 14, 13 and 11 give a maximal length sequence
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_next_bit()};
    end
    return value;
  endfunction

  function automatic logic [31:0] byte_reverse(input logic [31:0] value);
    logic [31:0] result;
    for (int b = 0; b < 4; b++) begin
      result[(3-b)*8 +: 8] = value[b*8 +: 8];
    end
    return result;
  endfunction

  // Returns {hit, slot} for the first valid rule whose leading bits match
  function automatic logic [4:0] expected_lookup(input logic [31:0] reg_value);
    logic [31:0] ip;
    logic [4:0]  result;
    bit          found;
    bit          match;
    ip = byte_reverse(reg_value);
    result = '0;
    found = 0;
    for (int k = 0; k < SLOT_COUNT; k++) begin
      if (ref_len[k] == 0) begin
        match = 1;
      end else begin
        match = (ip >> (32 - ref_len[k])) == (ref_prefix[k] >> (32 - ref_len[k]));
      end
      if (!found && ref_valid[k] && match) begin
        found = 1;
        result = {1'b1, 4'(k)};
      end
    end
    return result;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatch_count++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic write_rule(input int slot, input logic [31:0] prefix, input int len,
                            input bit valid);
    rule_wr_en     = 1'b1;
    rule_wr_slot   = SLOT_W'(slot);
    rule_wr_prefix = prefix;
    rule_wr_len    = PREFIX_LEN_W'(len);
    rule_wr_valid  = valid;
    ref_prefix[slot] = prefix;
    ref_len[slot]    = len;
    ref_valid[slot]  = valid;
    next_cycle();
    rule_wr_en = 1'b0;
  endtask

  task automatic write_src(input logic [3:0] strb, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = strb;
    io_addr    = IO_ADDR_WIDTH'(REG_SRC_IP) << REG_SEL_LSB;
    io_wr_data = data;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_src[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    next_cycle();
    io_en   = 1'b0;
    io_wen  = 1'b0;
    io_strb = '0;
  endtask

  // The register holds the address in network byte order
  task automatic write_ip(input logic [31:0] ip);
    write_src(4'hf, byte_reverse(ip));
  endtask

  // Latency counts cycles from the request cycle to the io_rd_valid cycle
  task automatic read_reg(input reg_sel_e sel, output logic [31:0] data, output int latency);
    int waited;
    bit seen;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_strb = '0;
    io_addr = IO_ADDR_WIDTH'(sel) << REG_SEL_LSB;
    next_cycle();
    io_en = 1'b0;
    waited = 1;
    seen = 0;
    data = '0;
    latency = 0;
    while (!seen && waited < READ_TIMEOUT) begin
      next_cycle();
      waited++;
      if (io_rd_valid) begin
        seen = 1;
        data = io_rd_data;
        latency = waited;
      end
    end
    assert (seen) else begin
      timeout_count++;
      $display("Read of register %0d got no io_rd_valid within %0d cycles", sel, waited);
    end
  endtask

  task automatic check_reg_read(input reg_sel_e sel, input string name,
                                input logic [31:0] exp);
    logic [31:0] data;
    int          latency;
    read_reg(sel, data, latency);
    check_value(name, data, exp);
    check_value({name, " latency"}, latency, 2);
  endtask

  task automatic lookup_and_check(input logic [31:0] ip);
    logic [31:0] data;
    logic [4:0]  exp;
    int          latency;
    write_ip(ip);
    exp = expected_lookup(model_src);
    read_reg(REG_MATCH, data, latency);
    check_value("io_rd_data (REG_MATCH)", data, 32'(exp[4]));
    read_reg(REG_SLOT, data, latency);
    check_value("io_rd_data (REG_SLOT)", data, 32'(exp[3:0]));
  endtask

  task automatic reset_state_test();
    check_reg_read(REG_MATCH, "io_rd_data (REG_MATCH)", 32'h0);
    check_reg_read(REG_SLOT, "io_rd_data (REG_SLOT)", 32'h0);
  endtask

  task automatic src_register_test();
    write_src(4'hf, 32'h11223344);
    check_reg_read(REG_SRC_IP, "io_rd_data (REG_SRC_IP)", model_src);
    write_src(4'b0101, 32'haabbccdd);
    check_reg_read(REG_SRC_IP, "io_rd_data (REG_SRC_IP)", model_src);
    write_src(4'b1000, 32'h99000000);
    check_reg_read(REG_SRC_IP, "io_rd_data (REG_SRC_IP)", model_src);
    check_reg_read(REG_RSVD, "io_rd_data (REG_RSVD)", 32'h0);
  endtask

  task automatic crafted_rules_test();
    write_rule(0, 32'h0a000000, 8, 1);
    write_rule(1, 32'h0a010000, 16, 1);
    write_rule(2, 32'hc0a80100, 24, 1);
    write_rule(3, 32'hc0a80000, 16, 1);
    write_rule(4, 32'hac100509, 32, 1);
    write_rule(5, 32'h08000000, 8, 0);
    write_rule(15, 32'h00000000, 0, 1);
    lookup_and_check(32'h0a010203);
    lookup_and_check(32'hc0a8014d);
    lookup_and_check(32'hc0a80707);
    lookup_and_check(32'hac100509);
    lookup_and_check(32'hac100508);
    lookup_and_check(32'h08080808);
    // Without the default rule the same address misses
    write_rule(15, 32'h00000000, 0, 0);
    lookup_and_check(32'h08080808);
  endtask

  // Slot k is compared in T+2+k, so a hit is readable in T+4+k and a miss in T+19
  task automatic stalled_read(input logic [31:0] ip);
    logic [31:0] data;
    logic [4:0]  exp;
    int          latency;
    write_ip(ip);
    exp = expected_lookup(model_src);
    read_reg(REG_MATCH, data, latency);
    check_value("io_rd_data (REG_MATCH)", data, 32'(exp[4]));
    assert (latency + 1 >= 3 && latency + 1 <= 19) else begin
      mismatch_count++;
      $display("Stalled read finished %0d cycles after the write, outside 3 to 19",
               latency + 1);
    end
    check_value("io_rd_valid cycle after write", latency + 1,
                exp[4] ? 4 + int'(exp[3:0]) : 19);
    read_reg(REG_SLOT, data, latency);
    check_value("io_rd_data (REG_SLOT)", data, 32'(exp[3:0]));
  endtask

  task automatic stall_test();
    stalled_read(32'h08080808);
    write_rule(15, 32'h00000000, 0, 1);
    stalled_read(32'h08080808);
    stalled_read(32'hc0a8014d);
    stalled_read(32'h0a010203);
  endtask

  // The first address would only hit the default rule, so its scan is still running
  // The second address hits slot 0, which only a scan that starts over can find in time
  task automatic restart_test();
    write_ip(32'h08080808);
    next_cycle();
    stalled_read(32'h0a010203);
  endtask

  task automatic random_table_test();
    logic [31:0] ip;
    logic [31:0] low;
    int          len;
    int          slot;
    int          hits;
    hits = 0;
    for (int s = 0; s < SLOT_COUNT; s++) begin
      len = int'(random_bits(6));
      if (len > 32) begin
        len -= 32;
      end
      write_rule(s, random_bits(32), len, random_bits(2) != 0);
    end
    for (int i = 0; i < 50; i++) begin
      if (random_bits(1)) begin
        // Borrow the upper half of a rule prefix so that some lookups hit
        slot = int'(random_bits(4));
        low = random_bits(16);
        ip = {ref_prefix[slot][31:16], low[15:0]};
      end else begin
        ip = random_bits(32);
      end
      lookup_and_check(ip);
      if (expected_lookup(model_src) >= 5'h10) begin
        hits++;
      end
    end
    $display("Random lookups: %0d of 50 hit a rule", hits);
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    io_en          = 1'b0;
    io_wen         = 1'b0;
    io_strb        = '0;
    io_addr        = '0;
    io_wr_data     = '0;
    rule_wr_en     = 1'b0;
    rule_wr_slot   = '0;
    rule_wr_prefix = '0;
    rule_wr_len    = '0;
    rule_wr_valid  = 1'b0;
    model_src      = '0;
    lfsr_state     = 16'd766;
    mismatch_count = 0;
    timeout_count  = 0;
    for (int s = 0; s < SLOT_COUNT; s++) begin
      ref_prefix[s] = '0;
      ref_len[s]    = 0;
      ref_valid[s]  = 0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    reset_state_test();
    src_register_test();
    crafted_rules_test();
    stall_test();
    restart_test();
    random_table_test();

    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== src/fw_accel_top.sv ====
`timescale 1ns/100ps

module fw_accel_top (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic                                   io_en,
  input  logic                                   io_wen,
  input  logic [fw_accel_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [fw_accel_pkg::IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [fw_accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [fw_accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                                   io_rd_valid,

  input  logic                                   rule_wr_en,
  input  logic [fw_rule_pkg::SLOT_W-1:0]         rule_wr_slot,
  input  logic [fw_rule_pkg::IP_W-1:0]           rule_wr_prefix,
  input  logic [fw_rule_pkg::PREFIX_LEN_W-1:0]   rule_wr_len,
  input  logic                                   rule_wr_valid
);

  import fw_accel_pkg::*;
  import fw_rule_pkg::*;

  logic [IO_DATA_WIDTH-1:0] src_ip;
  logic                     lookup_start;
  logic [IP_W-1:0]          lookup_addr;
  logic                     rd_req;
  reg_sel_e                 rd_sel;

  logic [SLOT_W-1:0]        scan_slot;
  logic [IP_W-1:0]          slot_prefix;
  logic [PREFIX_LEN_W-1:0]  slot_len;
  logic                     slot_valid;

  logic                     lookup_done;
  logic                     lookup_hit;
  logic [SLOT_W-1:0]        hit_slot;

  mmio_decode u_decode (
    .clk, .rst,
    .io_en, .io_wen, .io_strb, .io_addr, .io_wr_data,
    .src_ip, .lookup_start, .lookup_addr, .rd_req, .rd_sel
  );

  fw_rule_table u_rule_table (
    .clk, .rst,
    .rule_wr_en, .rule_wr_slot, .rule_wr_prefix, .rule_wr_len, .rule_wr_valid,
    .scan_slot, .slot_prefix, .slot_len, .slot_valid
  );

  fw_matcher u_matcher (
    .clk, .rst,
    .lookup_start, .lookup_addr,
    .scan_slot, .slot_prefix, .slot_len, .slot_valid,
    .lookup_done, .lookup_hit, .hit_slot
  );

  mmio_result u_result (
    .clk, .rst,
    .rd_req, .rd_sel, .src_ip,
    .lookup_done, .lookup_hit, .hit_slot,
    .io_rd_data, .io_rd_valid
  );

endmodule

// ==== src/mmio_result.sv ====
`timescale 1ns/100ps

module mmio_result (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic                                   rd_req,
  input  fw_accel_pkg::reg_sel_e                 rd_sel,
  input  logic [fw_accel_pkg::IO_DATA_WIDTH-1:0] src_ip,

  input  logic                                   lookup_done,
  input  logic                                   lookup_hit,
  input  logic [fw_rule_pkg::SLOT_W-1:0]         hit_slot,

  output logic [fw_accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                                   io_rd_valid
);

  import fw_accel_pkg::*;

  reg_sel_e stall_sel;
  logic     stall;
  logic     req_waits;

  // Register contents as seen by the core with unused bits reading zero
  function automatic logic [IO_DATA_WIDTH-1:0] read_value(reg_sel_e sel);
    logic [IO_DATA_WIDTH-1:0] value;
    case (sel)
      REG_SRC_IP: value = src_ip;
      REG_MATCH:  value = IO_DATA_WIDTH'(lookup_hit);
      REG_SLOT:   value = IO_DATA_WIDTH'(hit_slot);
      default:    value = '0;
    endcase
    return value;
  endfunction

  // A result read has to wait while a lookup is still in flight
  assign req_waits = rd_req && is_result_reg(rd_sel) && !lookup_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      stall       <= 1'b0;
    end else begin
      io_rd_valid <= 1'b0;
      if (req_waits) begin
        stall <= 1'b1;
      end else if (rd_req) begin
        io_rd_valid <= 1'b1;
      end else if (stall && lookup_done) begin
        io_rd_valid <= 1'b1;
        stall       <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_waits) begin
      stall_sel <= rd_sel;
    end
    if (rd_req && !req_waits) begin
      io_rd_data <= read_value(rd_sel);
    end else if (stall && lookup_done) begin
      io_rd_data <= read_value(stall_sel);
    end
  end

  // Each read produces exactly one valid pulse
  a_single_valid: assert property (
    @(posedge clk) disable iff (rst)
    (io_rd_valid && !rd_req && !stall) |=> !io_rd_valid
  );

endmodule

// ==== src/fw_matcher.sv ====
`timescale 1ns/100ps

module fw_matcher (
  input  logic                                 clk,
  input  logic                                 rst,

  input  logic                                 lookup_start,
  input  logic [fw_rule_pkg::IP_W-1:0]         lookup_addr,

  output logic [fw_rule_pkg::SLOT_W-1:0]       scan_slot,
  input  logic [fw_rule_pkg::IP_W-1:0]         slot_prefix,
  input  logic [fw_rule_pkg::PREFIX_LEN_W-1:0] slot_len,
  input  logic                                 slot_valid,

  output logic                                 lookup_done,
  output logic                                 lookup_hit,
  output logic [fw_rule_pkg::SLOT_W-1:0]       hit_slot
);

  import fw_rule_pkg::*;

  match_state_e    state;
  logic [IP_W-1:0] scan_addr;
  logic [IP_W-1:0] prefix_mask;
  logic            slot_hit;

  // The mask keeps the leading slot_len bits
  // A length of zero gives an empty mask that lets any address through
  assign prefix_mask = {IP_W{1'b1}} << (IP_W - int'(slot_len));

  assign slot_hit = slot_valid && (((scan_addr ^ slot_prefix) & prefix_mask) == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      scan_slot   <= '0;
      lookup_done <= 1'b1;
      lookup_hit  <= 1'b0;
      hit_slot    <= '0;
    end else if (lookup_start) begin
      // A new address aborts whatever scan is running
      state       <= SCAN;
      scan_slot   <= '0;
      lookup_done <= 1'b0;
      lookup_hit  <= 1'b0;
      hit_slot    <= '0;
    end else begin
      case (state)
        SCAN: begin
          if (slot_hit) begin
            state       <= DONE;
            lookup_done <= 1'b1;
            lookup_hit  <= 1'b1;
            hit_slot    <= scan_slot;
          end else if (scan_slot == LAST_SLOT) begin
            // Ran off the end of the table without a match
            state       <= DONE;
            lookup_done <= 1'b1;
          end else begin
            scan_slot <= scan_slot + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // The address is held for the whole scan while the source register moves on
  always_ff @(posedge clk) begin
    if (lookup_start) begin
      scan_addr <= lookup_addr;
    end
  end

  a_busy_not_done: assert property (
    @(posedge clk) disable iff (rst)
    (state == SCAN) |-> !lookup_done
  );

endmodule

// ==== src/fw_rule_table.sv ====
`timescale 1ns/100ps

module fw_rule_table (
  input  logic                                 clk,
  input  logic                                 rst,

  input  logic                                 rule_wr_en,
  input  logic [fw_rule_pkg::SLOT_W-1:0]       rule_wr_slot,
  input  logic [fw_rule_pkg::IP_W-1:0]         rule_wr_prefix,
  input  logic [fw_rule_pkg::PREFIX_LEN_W-1:0] rule_wr_len,
  input  logic                                 rule_wr_valid,

  input  logic [fw_rule_pkg::SLOT_W-1:0]       scan_slot,
  output logic [fw_rule_pkg::IP_W-1:0]         slot_prefix,
  output logic [fw_rule_pkg::PREFIX_LEN_W-1:0] slot_len,
  output logic                                 slot_valid
);

  import fw_rule_pkg::*;

  logic [IP_W-1:0]         rule_prefix [SLOT_COUNT];
  logic [PREFIX_LEN_W-1:0] rule_len    [SLOT_COUNT];
  logic [SLOT_COUNT-1:0]   rule_valid;

  // Prefix and length of each slot
  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rule_prefix[rule_wr_slot] <= rule_wr_prefix;
      rule_len[rule_wr_slot]    <= rule_wr_len;
    end
  end

  // After reset the table is empty
  always_ff @(posedge clk) begin
    if (rst) begin
      rule_valid <= '0;
    end else if (rule_wr_en) begin
      rule_valid[rule_wr_slot] <= rule_wr_valid;
    end
  end

  // Asynchronous read so the matcher sees one slot per cycle
  assign slot_prefix = rule_prefix[scan_slot];
  assign slot_len    = rule_len[scan_slot];
  assign slot_valid  = rule_valid[scan_slot];

  a_len_legal: assert property (
    @(posedge clk) disable iff (rst)
    rule_wr_en |-> (rule_wr_len <= MAX_PREFIX_LEN)
  );

endmodule

// ==== src/mmio_decode.sv ====
`timescale 1ns/100ps

module mmio_decode (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic                                   io_en,
  input  logic                                   io_wen,
  input  logic [fw_accel_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [fw_accel_pkg::IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [fw_accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,

  output logic [fw_accel_pkg::IO_DATA_WIDTH-1:0] src_ip,
  output logic                                   lookup_start,
  output logic [fw_rule_pkg::IP_W-1:0]           lookup_addr,
  output logic                                   rd_req,
  output fw_accel_pkg::reg_sel_e                 rd_sel
);

  import fw_accel_pkg::*;

  reg_sel_e io_sel;
  logic     wr_src_ip;
  logic     rd_access;

  // Only two address bits pick a register and the rest are ignored
  assign io_sel    = reg_sel_e'(io_addr[REG_SEL_LSB +: REG_SEL_W]);
  assign wr_src_ip = io_en && io_wen && (io_sel == REG_SRC_IP);
  assign rd_access = io_en && !io_wen;

  // Source address register with byte strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      src_ip <= '0;
    end else if (wr_src_ip) begin
      for (int b = 0; b < IO_STRB_WIDTH; b++) begin
        if (io_strb[b]) begin
          src_ip[b*8 +: 8] <= io_wr_data[b*8 +: 8];
        end
      end
    end
  end

  // Every accepted address write kicks off a fresh lookup one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      lookup_start <= 1'b0;
    end else begin
      lookup_start <= wr_src_ip;
    end
  end

  // Reads are passed on to the result stage with their selection
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_req <= 1'b0;
    end else begin
      rd_req <= rd_access;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_access) begin
      rd_sel <= io_sel;
    end
  end

  // The core writes the address as it sits in the packet, so the
  // matcher gets it with the byte order reversed
  assign lookup_addr = {src_ip[7:0], src_ip[15:8], src_ip[23:16], src_ip[31:24]};

  // The core may not write the address in back to back cycles
  a_start_single: assert property (
    @(posedge clk) disable iff (rst)
    lookup_start |=> !lookup_start
  );

endmodule

// ==== src/fw_rule_pkg.sv ====
package fw_rule_pkg;

  // Rule table geometry
  localparam int SLOT_COUNT = 16;
  localparam int SLOT_W     = 4;

  // IPv4 addresses and prefixes
  localparam int IP_W = 32;

  // A prefix length runs from 0 to 32 and so needs six bits
  localparam int PREFIX_LEN_W = 6;

  // Index of the final slot visited by a scan
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(SLOT_COUNT - 1);

  // Largest legal prefix length
  localparam logic [PREFIX_LEN_W-1:0] MAX_PREFIX_LEN = PREFIX_LEN_W'(IP_W);

  // Matcher states
  //   IDLE  nothing started since reset, or a finished result is parked
  //   SCAN  one slot is compared per cycle
  //   DONE  the cycle in which a finished result first shows
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    SCAN = 2'd1,
    DONE = 2'd2
  } match_state_e;

endpackage

// ==== src/fw_accel_pkg.sv ====
package fw_accel_pkg;

  // Core-side I/O port sizes as fixed by the accelerator slot of the core
  localparam int IO_DATA_WIDTH = 32;
  localparam int IO_STRB_WIDTH = IO_DATA_WIDTH / 8;
  localparam int IO_ADDR_WIDTH = 22;

  // Registers are word spaced, so the selection starts at address bit 2
  localparam int REG_SEL_LSB = 2;
  localparam int REG_SEL_W   = 2;

  // Register map of the accelerator
  //   REG_SRC_IP  source address in network byte order, read and write
  //   REG_MATCH   bit 0 is the match flag of the last lookup
  //   REG_SLOT    low bits hold the first matching slot
  //   REG_RSVD    always reads zero
  typedef enum logic [REG_SEL_W-1:0] {
    REG_SRC_IP = 2'd0,
    REG_MATCH  = 2'd1,
    REG_SLOT   = 2'd2,
    REG_RSVD   = 2'd3
  } reg_sel_e;

  // Reads of these registers depend on a finished lookup
  function automatic logic is_result_reg(reg_sel_e sel);
    logic result;
    result = (sel == REG_MATCH) || (sel == REG_SLOT);
    return result;
  endfunction

endpackage
